/* design/dm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug link types: DMI request/response structs, op/status enums
// register map and crossing depth constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dm_pkg;

  localparam int unsigned DMI_ADDR_W     = 7;
  localparam int unsigned DMI_FIFO_DEPTH = 2;  // per crossing, power of two

  // core-side register map
  localparam logic [DMI_ADDR_W-1:0] DATA0_ADDR = 7'h04;  // data0..data3 follow
  localparam int unsigned           NUM_DATA   = 4;
  localparam logic [DMI_ADDR_W-1:0] ID_ADDR    = 7'h11;  // read only
  localparam logic [31:0]           ID_VALUE   = 32'h0000_0d13;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  // 2'h1 left unused, same as the spec encoding
  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_FAILED  = 2'h2,
    DTM_BUSY    = 2'h3
  } dmi_resp_e;

  typedef struct packed {
    logic [DMI_ADDR_W-1:0] addr;
    dtm_op_e               op;
    logic [31:0]           data;
  } dmi_req_t;  // 41 bits

  typedef struct packed {
    logic [31:0] data;
    dmi_resp_e   resp;
  } dmi_resp_t;  // 34 bits

endpackage

`default_nettype wire

/* design/dmi_sync_2ff.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-flop synchronizer, async reset to zero, parameterized width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dmi_sync_2ff #(
  parameter int unsigned Width = 1  // 1 for resets, ptr width for gray pointers
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Width-1:0] meta_q;  // first stage, may go metastable

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= '0;
      q_o    <= '0;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule

`default_nettype wire

/* design/dmi_fifo_async.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-clock FIFO with gray-coded pointers, valid/ready on both ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dmi_fifo_async #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2   // power of two, at least 2
) (
  // write port
  input  logic             wclk_i,
  input  logic             wrst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  // read port
  input  logic             rclk_i,
  input  logic             rrst_ni,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int unsigned AW = $clog2(Depth);  // index bits, pointers carry one more

  logic [Width-1:0] mem_q [Depth];

  logic [AW:0] wbin_q, wgray_q, wbin_next;
  logic [AW:0] rgray_wsync, rbin_wsync;  // read ptr seen from write side
  logic [AW:0] rbin_q, rgray_q, rbin_next;
  logic [AW:0] wgray_rsync;              // write ptr seen from read side
  logic        wr_up_q;                  // write side out of reset
  logic        full, empty;
  logic        wfire, rfire;

  function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write domain
  assign wfire      = wvalid_i & wready_o;
  assign wbin_next  = wbin_q + 1'b1;
  assign rbin_wsync = gray2bin(rgray_wsync);
  // same index, wrap bit differs
  assign full       = (wbin_q[AW] != rbin_wsync[AW]) &&
                      (wbin_q[AW-1:0] == rbin_wsync[AW-1:0]);
  assign wready_o   = wr_up_q & ~full;  // held low until the first edge out of reset

  always_ff @(posedge wclk_i or negedge wrst_ni) begin
    if (!wrst_ni) begin
      wbin_q  <= '0;
      wgray_q <= '0;
      wr_up_q <= 1'b0;
    end else begin
      wr_up_q <= 1'b1;
      if (wfire) begin
        wbin_q  <= wbin_next;
        wgray_q <= bin2gray(wbin_next);  // registered so the sync sees one bit change
      end
    end
  end

  always_ff @(posedge wclk_i) begin
    if (wfire) begin
      mem_q[wbin_q[AW-1:0]] <= wdata_i;
    end
  end

  // read domain
  assign rfire     = rvalid_o & rready_i;
  assign rbin_next = rbin_q + 1'b1;
  assign empty     = (rgray_q == wgray_rsync);
  assign rvalid_o  = ~empty;
  assign rdata_o   = mem_q[rbin_q[AW-1:0]];  // slot is stable, writer is elsewhere

  always_ff @(posedge rclk_i or negedge rrst_ni) begin
    if (!rrst_ni) begin
      rbin_q  <= '0;
      rgray_q <= '0;
    end else if (rfire) begin
      rbin_q  <= rbin_next;
      rgray_q <= bin2gray(rbin_next);
    end
  end

  // pointer crossings
  dmi_sync_2ff #(.Width(AW + 1)) i_sync_wptr (
    .clk_i  (rclk_i),
    .rst_ni (rrst_ni),
    .d_i    (wgray_q),
    .q_o    (wgray_rsync)
  );

  dmi_sync_2ff #(.Width(AW + 1)) i_sync_rptr (
    .clk_i  (wclk_i),
    .rst_ni (wrst_ni),
    .d_i    (rgray_q),
    .q_o    (rgray_wsync)
  );

endmodule

`default_nettype wire

/* design/dmi_cdc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// JTAG to core DMI crossing: request/response FIFOs, reset sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dmi_cdc (
  // test controls
  input  logic              testmode_i,
  input  logic              test_rst_ni,
  // JTAG side, requester
  input  logic              tck_i,
  input  logic              trst_ni,
  input  dm_pkg::dmi_req_t  jtag_dmi_req_i,
  input  logic              jtag_dmi_valid_i,
  output logic              jtag_dmi_ready_o,
  input  logic              jtag_dmi_cdc_clear_i,  // sync to tck, resets both sides
  output dm_pkg::dmi_resp_t jtag_dmi_resp_o,
  output logic              jtag_dmi_valid_o,
  input  logic              jtag_dmi_ready_i,
  // core side, target
  input  logic              clk_i,
  input  logic              rst_ni,
  output logic              core_dmi_rst_no,
  output dm_pkg::dmi_req_t  core_dmi_req_o,
  output logic              core_dmi_valid_o,
  input  logic              core_dmi_ready_i,
  input  dm_pkg::dmi_resp_t core_dmi_resp_i,
  input  logic              core_dmi_valid_i,
  output logic              core_dmi_ready_o
);

  import dm_pkg::*;

  logic jtag_rstn;        // tck side, low on trst or clear
  logic jtag_fifo_rstn;   // reset for the tck-side FIFO ports
  logic core_rstn_async;  // asserts at once, from either side
  logic core_rstn;        // released in sync with clk_i
  logic core_fifo_rstn;   // after test mux

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      jtag_rstn <= 1'b0;
    end else begin
      jtag_rstn <= ~jtag_dmi_cdc_clear_i;  // back high one edge after clear ends
    end
  end

  assign core_rstn_async = rst_ni & jtag_rstn;

  dmi_sync_2ff #(.Width(1)) i_core_rst_sync (
    .clk_i  (clk_i),
    .rst_ni (core_rstn_async),
    .d_i    (1'b1),
    .q_o    (core_rstn)
  );

  // test mode hands both sides to test_rst_ni so the pointers stay paired
  assign core_fifo_rstn  = testmode_i ? test_rst_ni : core_rstn;
  assign jtag_fifo_rstn  = testmode_i ? test_rst_ni : jtag_rstn;
  assign core_dmi_rst_no = core_fifo_rstn;

  // requests, tck -> clk
  dmi_fifo_async #(
    .Width ($bits(dmi_req_t)),
    .Depth (DMI_FIFO_DEPTH)
  ) i_cdc_req (
    .wclk_i   (tck_i),
    .wrst_ni  (jtag_fifo_rstn),
    .wvalid_i (jtag_dmi_valid_i),
    .wready_o (jtag_dmi_ready_o),
    .wdata_i  (jtag_dmi_req_i),
    .rclk_i   (clk_i),
    .rrst_ni  (core_fifo_rstn),
    .rvalid_o (core_dmi_valid_o),
    .rready_i (core_dmi_ready_i),
    .rdata_o  (core_dmi_req_o)
  );

  // responses, clk -> tck
  dmi_fifo_async #(
    .Width ($bits(dmi_resp_t)),
    .Depth (DMI_FIFO_DEPTH)
  ) i_cdc_resp (
    .wclk_i   (clk_i),
    .wrst_ni  (core_fifo_rstn),
    .wvalid_i (core_dmi_valid_i),
    .wready_o (core_dmi_ready_o),
    .wdata_i  (core_dmi_resp_i),
    .rclk_i   (tck_i),
    .rrst_ni  (jtag_fifo_rstn),
    .rvalid_o (jtag_dmi_valid_o),
    .rready_i (jtag_dmi_ready_i),
    .rdata_o  (jtag_dmi_resp_o)
  );

endmodule

`default_nettype wire

/* design/dmi_reg_target.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core-side DMI target: four data registers, read-only ID, one response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dmi_reg_target (
  input  logic              clk_i,
  input  logic              rst_ni,
  // request in
  input  dm_pkg::dmi_req_t  req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  // response out
  output dm_pkg::dmi_resp_t resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i
);

  import dm_pkg::*;

  localparam int unsigned IdxW = $clog2(NUM_DATA);

  logic [31:0]           data_q [NUM_DATA];
  dmi_resp_t             resp_q, resp_d;
  logic                  resp_valid_q;   // a response is waiting
  logic                  req_fire, resp_fire;
  logic                  data_hit, id_hit;
  logic                  data_we;
  logic [DMI_ADDR_W-1:0] data_offs;      // addr relative to data0
  logic [IdxW-1:0]       data_idx;

  assign req_ready_o  = ~resp_valid_q;  // one transaction at a time
  assign req_fire     = req_valid_i & req_ready_o;
  assign resp_valid_o = resp_valid_q;
  assign resp_fire    = resp_valid_q & resp_ready_i;
  assign resp_o       = resp_q;

  // address decode
  assign data_offs = req_i.addr - DATA0_ADDR;
  assign data_hit  = (req_i.addr >= DATA0_ADDR) && (data_offs < NUM_DATA);
  assign data_idx  = data_offs[IdxW-1:0];
  assign id_hit    = (req_i.addr == ID_ADDR);
  assign data_we   = req_fire && (req_i.op == DTM_WRITE) && data_hit;

  always_comb begin
    resp_d.data = '0;
    resp_d.resp = DTM_SUCCESS;
    case (req_i.op)
      DTM_NOP: ;  // plain success, no data
      DTM_READ: begin
        if (data_hit) begin
          resp_d.data = data_q[data_idx];
        end else if (id_hit) begin
          resp_d.data = ID_VALUE;
        end else begin
          resp_d.resp = DTM_FAILED;  // unmapped
        end
      end
      DTM_WRITE: begin
        if (!data_hit) begin
          resp_d.resp = DTM_FAILED;  // ID is read only, rest unmapped
        end
      end
      default: resp_d.resp = DTM_FAILED;  // reserved op
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      for (int i = 0; i < NUM_DATA; i++) begin
        data_q[i] <= '0;
      end
    end else begin
      if (req_fire) begin
        resp_valid_q <= 1'b1;
      end else if (resp_fire) begin
        resp_valid_q <= 1'b0;
      end
      if (data_we) begin
        data_q[data_idx] <= req_i.data;  // same edge as response valid
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q <= resp_d;
    end
  end

endmodule

`default_nettype wire

/* design/dmi_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMI link top: clock crossing plus core-side debug register target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dmi_top (
  input  logic              testmode_i,
  input  logic              test_rst_ni,
  input  logic              tck_i,
  input  logic              trst_ni,
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              jtag_dmi_cdc_clear_i,
  // JTAG-side DMI
  input  dm_pkg::dmi_req_t  jtag_dmi_req_i,
  input  logic              jtag_dmi_valid_i,
  output logic              jtag_dmi_ready_o,
  output dm_pkg::dmi_resp_t jtag_dmi_resp_o,
  output logic              jtag_dmi_valid_o,
  input  logic              jtag_dmi_ready_i
);

  import dm_pkg::*;

  // core clock domain
  dmi_req_t  core_dmi_req;
  logic      core_dmi_valid, core_dmi_ready;
  dmi_resp_t core_dmi_resp;
  logic      core_dmi_resp_valid, core_dmi_resp_ready;
  logic      core_dmi_rst_n;   // sequenced, from the crossing

  dmi_cdc i_dmi_cdc (
    .testmode_i           (testmode_i),
    .test_rst_ni          (test_rst_ni),
    .tck_i                (tck_i),
    .trst_ni              (trst_ni),
    .jtag_dmi_req_i       (jtag_dmi_req_i),
    .jtag_dmi_valid_i     (jtag_dmi_valid_i),
    .jtag_dmi_ready_o     (jtag_dmi_ready_o),
    .jtag_dmi_cdc_clear_i (jtag_dmi_cdc_clear_i),
    .jtag_dmi_resp_o      (jtag_dmi_resp_o),
    .jtag_dmi_valid_o     (jtag_dmi_valid_o),
    .jtag_dmi_ready_i     (jtag_dmi_ready_i),
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .core_dmi_rst_no      (core_dmi_rst_n),
    .core_dmi_req_o       (core_dmi_req),
    .core_dmi_valid_o     (core_dmi_valid),
    .core_dmi_ready_i     (core_dmi_ready),
    .core_dmi_resp_i      (core_dmi_resp),
    .core_dmi_valid_i     (core_dmi_resp_valid),
    .core_dmi_ready_o     (core_dmi_resp_ready)
  );

  dmi_reg_target i_dmi_reg_target (
    .clk_i        (clk_i),
    .rst_ni       (core_dmi_rst_n),  // follows clear and test reset
    .req_i        (core_dmi_req),
    .req_valid_i  (core_dmi_valid),
    .req_ready_o  (core_dmi_ready),
    .resp_o       (core_dmi_resp),
    .resp_valid_o (core_dmi_resp_valid),
    .resp_ready_i (core_dmi_resp_ready)
  );

endmodule

`default_nettype wire

/* testbench/tb_dmi_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMI driver/checker tasks, LFSR stimulus, register model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_DMI_TASKS_SVH
`define TB_DMI_TASKS_SVH

  logic [31:0] lfsr_state = 32'h6e3e_b353;
  logic [31:0] model_q [NUM_DATA];  // expected data registers

  // fibonacci, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};  // one step per bit
    end
    return w;
  endfunction

  function automatic void model_clear();
    for (int i = 0; i < NUM_DATA; i++) begin
      model_q[i] = '0;
    end
  endfunction

  // expected response per register map, updates model on writes
  function automatic dmi_resp_t model_access(input dmi_req_t req);
    dmi_resp_t   r;
    int unsigned idx;
    logic        hit;
    r.data = '0;
    r.resp = DTM_SUCCESS;
    hit = (req.addr >= DATA0_ADDR) && (req.addr < DATA0_ADDR + NUM_DATA);
    idx = req.addr - DATA0_ADDR;
    case (req.op)
      DTM_NOP: ;
      DTM_READ: begin
        if (hit) r.data = model_q[idx];
        else if (req.addr == ID_ADDR) r.data = ID_VALUE;
        else r.resp = DTM_FAILED;
      end
      DTM_WRITE: begin
        if (hit) model_q[idx] = req.data;
        else r.resp = DTM_FAILED;  // ID or hole
      end
      default: r.resp = DTM_FAILED;
    endcase
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_resp(input dmi_resp_t exp, input dmi_resp_t act);
    check_value("status", exp.resp, act.resp);
    check_value("data", exp.data, act.data);
  endtask

  // polls request ready at 1 ns past the edge
  task automatic wait_ready(input int limit, output bit ok);
    int cnt;
    cnt = 0;
    while (!jtag_req_ready && cnt < limit) begin
      @(posedge tck_i);
      #1;
      cnt++;
    end
    ok = jtag_req_ready;
  endtask

  task automatic wait_link_ready();
    bit ok;
    wait_ready(TIMEOUT, ok);
    if (!ok) begin
      $display("%s: request port not ready after %0d tck cycles", test_name, TIMEOUT);
      fail_run();
    end
  endtask

  task automatic dmi_send(input dmi_req_t req);
    wait_link_ready();
    jtag_req       = req;
    jtag_req_valid = 1'b1;  // ready seen high, accepted on this edge
    @(posedge tck_i);
    #1;
    jtag_req_valid = 1'b0;
  endtask

  task automatic dmi_recv(output dmi_resp_t resp);
    int cnt;
    cnt = 0;
    jtag_resp_ready = 1'b1;
    while (!jtag_resp_valid) begin
      @(posedge tck_i);
      #1;
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("%s: no response within %0d tck cycles", test_name, TIMEOUT);
        fail_run();
      end
    end
    resp = jtag_resp;  // stable until the edge
    @(posedge tck_i);
    #1;
    jtag_resp_ready = 1'b0;
  endtask

  task automatic dmi_xfer(input dtm_op_e op, input logic [DMI_ADDR_W-1:0] addr,
                          input logic [31:0] data, output dmi_resp_t act);
    dmi_req_t  req;
    dmi_resp_t exp;
    req.addr = addr;
    req.op   = op;
    req.data = data;
    exp      = model_access(req);
    dmi_send(req);
    dmi_recv(act);
    check_resp(exp, act);
  endtask

`endif

/* testbench/tb_dmi_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMI link testbench with clocks, resets, DUT and directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_dmi_top;

  import dm_pkg::*;

  localparam int TIMEOUT = 200;  // tck cycles per wait
  localparam int SETTLE  = 24;   // quiet window that counts as a stall

  logic      tck_i, clk_i;
  logic      trst_ni, rst_ni;
  logic      testmode, test_rst_n;
  logic      cdc_clear;
  dmi_req_t  jtag_req;
  logic      jtag_req_valid, jtag_req_ready;
  dmi_resp_t jtag_resp;
  logic      jtag_resp_valid, jtag_resp_ready;
  string     test_name;

  task automatic fail_run();
    $display("Something failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  `include "tb_dmi_tasks.svh"

  initial begin
    tck_i = 1'b0;
    forever #4 tck_i = ~tck_i;  // 8 ns
  end

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns and unrelated to tck
  end

  dmi_top dut_i (
    .testmode_i           (testmode),
    .test_rst_ni          (test_rst_n),
    .tck_i                (tck_i),
    .trst_ni              (trst_ni),
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .jtag_dmi_cdc_clear_i (cdc_clear),
    .jtag_dmi_req_i       (jtag_req),
    .jtag_dmi_valid_i     (jtag_req_valid),
    .jtag_dmi_ready_o     (jtag_req_ready),
    .jtag_dmi_resp_o      (jtag_resp),
    .jtag_dmi_valid_o     (jtag_resp_valid),
    .jtag_dmi_ready_i     (jtag_resp_ready)
  );

  // every data register against the model
  task automatic read_all_data();
    dmi_resp_t act;
    for (int i = 0; i < NUM_DATA; i++) begin
      dmi_xfer(DTM_READ, DMI_ADDR_W'(DATA0_ADDR + i), '0, act);
    end
  endtask

  task automatic run_reset_state();
    dmi_resp_t act;
    test_name = "reset_state";
    wait_link_ready();
    check_value("response valid", 1'b0, jtag_resp_valid);  // tck side out of reset
    read_all_data();  // model is all zero here
    dmi_xfer(DTM_READ, ID_ADDR, '0, act);
    check_value("id", ID_VALUE, act.data);
  endtask

  task automatic run_write_read(input string name);
    dmi_resp_t act;
    test_name = name;
    for (int i = 0; i < NUM_DATA; i++) begin
      dmi_xfer(DTM_WRITE, DMI_ADDR_W'(DATA0_ADDR + i), rand_word(), act);
    end
    read_all_data();
  endtask

  task automatic run_error_codes();
    dmi_resp_t act;
    test_name = "error_codes";
    dmi_xfer(DTM_WRITE, ID_ADDR, rand_word(), act);
    check_value("id write status", DTM_FAILED, act.resp);
    dmi_xfer(DTM_READ, ID_ADDR, '0, act);
    check_value("id after write", ID_VALUE, act.data);
    dmi_xfer(DTM_READ, 7'h08, '0, act);  // one past data3
    check_value("unmapped read", DTM_FAILED, act.resp);
    dmi_xfer(DTM_WRITE, 7'h7f, rand_word(), act);
    check_value("unmapped write", DTM_FAILED, act.resp);
    dmi_xfer(DTM_NOP, DATA0_ADDR, rand_word(), act);
    check_value("nop status", DTM_SUCCESS, act.resp);
    check_value("nop data", 32'h0, act.data);
  endtask

  task automatic run_backpressure();
    dmi_req_t  req;
    dmi_resp_t exp_q[$];
    dmi_resp_t act;
    bit        ok;
    int        sent;
    test_name = "backpressure";
    sent      = 0;
    ok        = 1'b1;
    while (ok && sent < 12) begin  // response ready held low
      wait_ready(SETTLE, ok);
      if (ok) begin
        req.addr = DMI_ADDR_W'(DATA0_ADDR + (sent / 2) % NUM_DATA);
        req.op   = sent[0] ? DTM_READ : DTM_WRITE;  // write then read back
        req.data = rand_word();
        exp_q.push_back(model_access(req));
        dmi_send(req);
        sent++;
      end
    end
    if (ok || sent < 2) begin
      $display("backpressure: request port did not stall after %0d requests", sent);
      fail_run();
    end
    while (exp_q.size() > 0) begin
      dmi_recv(act);
      check_resp(exp_q.pop_front(), act);  // request order
    end
  endtask

  task automatic run_cdc_clear();
    test_name = "cdc_clear";
    cdc_clear = 1'b1;
    @(posedge tck_i);
    #1;
    cdc_clear = 1'b0;
    model_clear();
    wait_link_ready();
    read_all_data();
  endtask

  task automatic run_test_reset();
    testmode = 1'b1;  // test_rst_n still high
    run_write_read("test_reset");
    test_rst_n = 1'b0;
    @(posedge tck_i);
    #1;
    test_rst_n = 1'b1;
    model_clear();
    wait_link_ready();
    read_all_data();
  endtask

  initial begin
    trst_ni         = 1'b0;
    rst_ni          = 1'b0;
    testmode        = 1'b0;
    test_rst_n      = 1'b1;
    cdc_clear       = 1'b0;
    jtag_req        = '0;
    jtag_req_valid  = 1'b0;
    jtag_resp_ready = 1'b0;
    test_name       = "init";
    model_clear();
    repeat (5) @(posedge tck_i);
    #1;
    trst_ni = 1'b1;
    rst_ni  = 1'b1;
    run_reset_state();
    run_write_read("write_read");
    run_error_codes();
    run_backpressure();
    run_cdc_clear();
    run_test_reset();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+testbench
design/dm_pkg.sv
design/dmi_sync_2ff.sv
design/dmi_fifo_async.sv
design/dmi_cdc.sv
design/dmi_reg_target.sv
design/dmi_top.sv
testbench/tb_dmi_top.sv
